/* logic/rib_pkg.sv */
package rib_pkg;

    typedef logic [31:0] rib_addr_t;
    typedef logic [31:0] rib_data_t;

    typedef struct packed {
        rib_addr_t addr;
        rib_data_t wdata;
        logic      we;
    } rib_req_t;

    typedef struct packed {
        logic [15:0] tx_data_num;
        logic        tx_enable;
        logic        fifo_wr_en;
        logic [31:0] board_ip;
        logic [31:0] des_ip;
        logic [15:0] board_port;
        logic [15:0] des_port;
    } udp_cfg_t;

    // Levels from the network side
    typedef struct packed {
        logic tx_done;
        logic busy;
        logic end_tran;
        logic tx_req;
        logic prog_empty;   // Packet FIFO below threshold
    } udp_stat_t;

    // Offsets in the low 16 address bits
    localparam logic [15:0] REG_UDP_CONFIG = 16'h0010;
    localparam logic [15:0] REG_BOARD_IP   = 16'h0014;
    localparam logic [15:0] REG_DES_IP     = 16'h0018;
    localparam logic [15:0] REG_BOARD_PORT = 16'h001C;
    localparam logic [15:0] REG_DES_PORT   = 16'h0020;
    localparam logic [15:0] REG_SYS_STATUS = 16'h0028;
    localparam logic [15:0] REG_TEST       = 16'h002C;
    localparam logic [15:0] REG_SYS_MODE   = 16'h0030;

    // Window select is the top offset nibble
    localparam logic [3:0] WIN_ADC_DATA = 4'h1;
    localparam logic [3:0] WIN_BASELINE = 4'h2;
    localparam logic [3:0] WIN_NOISE    = 4'h3;
    localparam int CH_STRIDE_SHIFT = 3;     // 8 bytes per channel

    localparam rib_data_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    localparam logic [15:0] RST_TX_DATA_NUM = 16'd100;
    localparam logic [31:0] RST_BOARD_IP    = {8'd192, 8'd168, 8'd185, 8'd111};
    localparam logic [31:0] RST_DES_IP      = {8'd192, 8'd168, 8'd185, 8'd243};
    localparam logic [15:0] RST_PORT        = 16'd1234;

endpackage

/* logic/fee_pkg.sv */
package fee_pkg;

    localparam int NUM_CHANNELS = 8;
    localparam int ADC_WIDTH    = 12;
    localparam int DATA_WIDTH   = 16;

    typedef logic [ADC_WIDTH-1:0]  adc_sample_t;
    typedef logic [DATA_WIDTH-1:0] chan_word_t;
    typedef adc_sample_t [NUM_CHANNELS-1:0] adc_bus_t;
    typedef chan_word_t  [NUM_CHANNELS-1:0] chan_bank_t;

    typedef logic [4:0] fee_mode_t;
    localparam fee_mode_t MODE_IDLE        = 5'd0;
    localparam fee_mode_t MODE_CALIBRATION = 5'd1;
    localparam fee_mode_t MODE_ACQUISITION = 5'd2;

    // Status as written by software
    typedef logic [4:0] sys_status_t;
    localparam sys_status_t STAT_WAIT            = 5'd0;
    localparam sys_status_t STAT_INIT_FINISH     = 5'd1;
    localparam sys_status_t STAT_MEASURE_START   = 5'd2;
    localparam sys_status_t STAT_MEASURE_FINISH  = 5'd3;
    localparam sys_status_t STAT_CLUSTER_FINDING = 5'd4;
    localparam sys_status_t STAT_UDP_REQ_WAIT    = 5'd7;
    localparam sys_status_t STAT_UDP_REQ         = 5'd8;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CAPTURE,
        S_TRANSMIT,
        S_MESSAGE
    } ctrl_state_e;

    localparam fee_mode_t RST_MODE = MODE_CALIBRATION;

endpackage

/* logic/rib_regs.sv */
`timescale 1ns/1ps

module rib_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  rib_pkg::rib_req_t    rib_req_i,
    input  fee_pkg::adc_bus_t    adc_data_i,
    input  logic                 adc_data_ready_i,
    input  logic                 capture_en_i,
    output rib_pkg::udp_cfg_t    udp_cfg_o,
    output fee_pkg::sys_status_t sys_status_o,
    output fee_pkg::fee_mode_t   cfg_mode_o,
    output rib_pkg::rib_data_t   test_word_o,
    output fee_pkg::chan_bank_t  baseline_o,
    output fee_pkg::chan_bank_t  noise_o,
    output fee_pkg::chan_bank_t  samples_o
);

    logic [15:0]                          offset;
    logic [11-rib_pkg::CH_STRIDE_SHIFT:0] ch_idx;
    logic                                 ch_ok;
    rib_pkg::rib_data_t                   wdata;

    assign offset = rib_req_i.addr[15:0];
    assign ch_idx = offset[11:rib_pkg::CH_STRIDE_SHIFT];
    assign ch_ok  = ch_idx < fee_pkg::NUM_CHANNELS;
    assign wdata  = rib_req_i.wdata;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            udp_cfg_o.tx_data_num <= rib_pkg::RST_TX_DATA_NUM;
            udp_cfg_o.tx_enable   <= 1'b1;
            udp_cfg_o.fifo_wr_en  <= 1'b0;
            udp_cfg_o.board_ip    <= rib_pkg::RST_BOARD_IP;
            udp_cfg_o.des_ip      <= rib_pkg::RST_DES_IP;
            udp_cfg_o.board_port  <= rib_pkg::RST_PORT;
            udp_cfg_o.des_port    <= rib_pkg::RST_PORT;
            sys_status_o          <= fee_pkg::STAT_WAIT;
            cfg_mode_o            <= fee_pkg::RST_MODE;
            test_word_o           <= '0;
        end else if (rib_req_i.we) begin
            case (offset)
                rib_pkg::REG_UDP_CONFIG: begin
                    udp_cfg_o.tx_data_num <= wdata[15:0];
                    udp_cfg_o.tx_enable   <= wdata[16];
                    udp_cfg_o.fifo_wr_en  <= wdata[17];
                end
                rib_pkg::REG_BOARD_IP:   udp_cfg_o.board_ip   <= wdata;
                rib_pkg::REG_DES_IP:     udp_cfg_o.des_ip     <= wdata;
                rib_pkg::REG_BOARD_PORT: udp_cfg_o.board_port <= wdata[15:0];
                rib_pkg::REG_DES_PORT:   udp_cfg_o.des_port   <= wdata[15:0];
                rib_pkg::REG_SYS_STATUS: sys_status_o <= wdata[4:0];
                rib_pkg::REG_TEST:       test_word_o  <= wdata;
                rib_pkg::REG_SYS_MODE:   cfg_mode_o   <= wdata[4:0];
                default: ;              // Windows handled below
            endcase
        end
    end

    // Channels past the bank drop their calibration writes
    always_ff @(posedge clk) begin
        if (rib_req_i.we && ch_ok) begin
            if (offset[15:12] == rib_pkg::WIN_BASELINE) begin
                baseline_o[ch_idx] <= fee_pkg::chan_word_t'(wdata);
            end
            if (offset[15:12] == rib_pkg::WIN_NOISE) begin
                noise_o[ch_idx] <= fee_pkg::chan_word_t'(wdata);
            end
        end
    end

    // Samples latch only while the FSM captures
    always_ff @(posedge clk) begin
        if (adc_data_ready_i && capture_en_i) begin
            for (int i = 0; i < fee_pkg::NUM_CHANNELS; i++) begin
                samples_o[i] <= fee_pkg::chan_word_t'(adc_data_i[i]);   // Zero-extend
            end
        end
    end

endmodule

/* logic/rib_readback.sv */
`timescale 1ns/1ps

module rib_readback (
    input  rib_pkg::rib_addr_t   rib_addr_i,
    input  rib_pkg::udp_cfg_t    udp_cfg_i,
    input  fee_pkg::sys_status_t sys_status_i,
    input  fee_pkg::fee_mode_t   fee_mode_i,
    input  logic                 udp_tx_req_i,
    input  rib_pkg::rib_data_t   test_word_i,
    input  fee_pkg::chan_bank_t  baseline_i,
    input  fee_pkg::chan_bank_t  noise_i,
    input  fee_pkg::chan_bank_t  samples_i,
    output rib_pkg::rib_data_t   rib_rdata_o
);

    logic [15:0]                          offset;
    logic [11-rib_pkg::CH_STRIDE_SHIFT:0] ch_idx;
    logic                                 ch_ok;
    fee_pkg::sys_status_t                 status_rd;

    assign offset = rib_addr_i[15:0];
    assign ch_idx = offset[11:rib_pkg::CH_STRIDE_SHIFT];
    assign ch_ok  = ch_idx < fee_pkg::NUM_CHANNELS;

    // Status seen by software depends on the operating mode
    always_comb begin
        status_rd = sys_status_i;
        if (fee_mode_i == fee_pkg::MODE_CALIBRATION &&
            sys_status_i != fee_pkg::STAT_MEASURE_FINISH) begin
            status_rd = fee_pkg::STAT_MEASURE_START;
        end else if (fee_mode_i == fee_pkg::MODE_IDLE) begin
            status_rd = fee_pkg::STAT_WAIT;
        end else if (fee_mode_i == fee_pkg::MODE_ACQUISITION) begin
            if (sys_status_i == fee_pkg::STAT_UDP_REQ_WAIT) begin
                status_rd = udp_tx_req_i ? fee_pkg::STAT_UDP_REQ : '0;
            end else begin
                status_rd = fee_pkg::STAT_CLUSTER_FINDING;
            end
        end
    end

    always_comb begin
        rib_rdata_o = rib_pkg::UNMAPPED_DATA;
        case (offset)
            rib_pkg::REG_UDP_CONFIG: begin
                rib_rdata_o = {14'h0, udp_cfg_i.fifo_wr_en, udp_cfg_i.tx_enable,
                               udp_cfg_i.tx_data_num};
            end
            rib_pkg::REG_BOARD_IP:   rib_rdata_o = udp_cfg_i.board_ip;
            rib_pkg::REG_DES_IP:     rib_rdata_o = udp_cfg_i.des_ip;
            rib_pkg::REG_BOARD_PORT: rib_rdata_o = rib_pkg::rib_data_t'(udp_cfg_i.board_port);
            rib_pkg::REG_DES_PORT:   rib_rdata_o = rib_pkg::rib_data_t'(udp_cfg_i.des_port);
            rib_pkg::REG_SYS_STATUS: rib_rdata_o = rib_pkg::rib_data_t'(status_rd);
            rib_pkg::REG_TEST:       rib_rdata_o = test_word_i;
            rib_pkg::REG_SYS_MODE:   rib_rdata_o = rib_pkg::rib_data_t'(fee_mode_i); // Operating
            default: begin
                if (ch_ok) begin
                    case (offset[15:12])
                        rib_pkg::WIN_ADC_DATA:
                            rib_rdata_o = rib_pkg::rib_data_t'(samples_i[ch_idx]);
                        rib_pkg::WIN_BASELINE:
                            rib_rdata_o = rib_pkg::rib_data_t'(baseline_i[ch_idx]);
                        rib_pkg::WIN_NOISE:
                            rib_rdata_o = rib_pkg::rib_data_t'(noise_i[ch_idx]);
                        default: ;
                    endcase
                end
            end
        endcase
    end

endmodule

/* logic/fee_ctrl_fsm.sv */
`timescale 1ns/1ps

module fee_ctrl_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  fee_pkg::fee_mode_t   cfg_mode_i,
    input  fee_pkg::sys_status_t sys_status_i,
    input  logic                 cfg_fifo_wr_en_i,
    input  logic                 cfg_tx_enable_i,
    input  rib_pkg::udp_stat_t   udp_stat_i,
    output fee_pkg::fee_mode_t   fee_mode_o,
    output logic                 fifo_wr_en_o,
    output logic                 udp_tx_enable_o,
    output logic                 message_sending_o
);

    fee_pkg::ctrl_state_e state;
    fee_pkg::fee_mode_t   mode_q;
    logic                 mode_changed;
    logic                 run;
    logic                 tx_go;
    logic                 meas_done;

    assign mode_changed = mode_q != cfg_mode_i;
    assign meas_done    = fee_mode_o == fee_pkg::MODE_CALIBRATION &&
                          sys_status_i == fee_pkg::STAT_MEASURE_FINISH;

    // Calibration waits for the measurement, acquisition for FIFO data
    assign tx_go = cfg_tx_enable_i && !udp_stat_i.end_tran &&
                   (meas_done || (fee_mode_o == fee_pkg::MODE_ACQUISITION &&
                                  !udp_stat_i.prog_empty));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode_q     <= fee_pkg::RST_MODE;   // Same as the register reset so no message at start
            run        <= 1'b0;
            state      <= fee_pkg::S_IDLE;
            fee_mode_o <= fee_pkg::MODE_IDLE;
        end else begin
            mode_q <= cfg_mode_i;
            if (sys_status_i == fee_pkg::STAT_INIT_FINISH) begin
                run <= 1'b1;                    // Sticky until reset
            end
            if (mode_changed) begin
                state      <= fee_pkg::S_MESSAGE;
                fee_mode_o <= cfg_mode_i;
            end else begin
                case (state)
                    fee_pkg::S_IDLE: begin
                        if (cfg_fifo_wr_en_i && run && fee_mode_o != fee_pkg::MODE_IDLE) begin
                            state <= fee_pkg::S_CAPTURE;
                        end
                    end
                    fee_pkg::S_CAPTURE: begin
                        if (tx_go) state <= fee_pkg::S_TRANSMIT;
                    end
                    fee_pkg::S_TRANSMIT: begin
                        if (udp_stat_i.end_tran || !udp_stat_i.busy) begin
                            state <= fee_pkg::S_IDLE;
                            if (meas_done) fee_mode_o <= fee_pkg::MODE_IDLE;
                        end
                    end
                    fee_pkg::S_MESSAGE: begin
                        if (udp_stat_i.tx_done || udp_stat_i.end_tran) state <= fee_pkg::S_IDLE;
                    end
                    default: state <= fee_pkg::S_IDLE;
                endcase
            end
        end
    end

    assign fifo_wr_en_o      = state == fee_pkg::S_CAPTURE || state == fee_pkg::S_TRANSMIT;
    assign udp_tx_enable_o   = state == fee_pkg::S_TRANSMIT || state == fee_pkg::S_MESSAGE;
    assign message_sending_o = state == fee_pkg::S_MESSAGE;

endmodule

/* logic/packet_trigger.sv */
`timescale 1ns/1ps

module packet_trigger (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 udp_tx_done_i,
    input  logic                 udp_tx_enable_i,
    input  fee_pkg::sys_status_t sys_status_i,
    output logic                 data_accept_o
);

    logic tx_done_q;
    logic done_edge;
    logic monitoring;
    logic first_sent;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tx_done_q     <= 1'b0;
            done_edge     <= 1'b0;
            monitoring    <= 1'b0;
            first_sent    <= 1'b0;
            data_accept_o <= 1'b0;
        end else begin
            tx_done_q <= udp_tx_done_i;
            done_edge <= udp_tx_done_i && !tx_done_q;
            if (done_edge) monitoring <= 1'b1;

            // First packet and finished measurement take priority
            if ((udp_tx_enable_i && !first_sent) ||
                sys_status_i == fee_pkg::STAT_MEASURE_FINISH) begin
                data_accept_o <= 1'b1;
                first_sent    <= 1'b1;
                monitoring    <= 1'b0;
            end else if (monitoring) begin
                data_accept_o <= 1'b1;      // One pulse per done edge
                monitoring    <= 1'b0;
            end else begin
                data_accept_o <= 1'b0;
            end
        end
    end

endmodule

/* logic/fee_top.sv */
`timescale 1ns/1ps

module fee_top (
    input  logic               clk,
    input  logic               rst,
    input  rib_pkg::rib_req_t  rib_req_i,
    output rib_pkg::rib_data_t rib_rdata_o,
    input  fee_pkg::adc_bus_t  adc_data_i,
    input  logic               adc_data_ready_i,
    input  rib_pkg::udp_stat_t udp_stat_i,
    output rib_pkg::udp_cfg_t  udp_cfg_o,
    output fee_pkg::fee_mode_t fee_mode_o,
    output logic               fifo_wr_en_o,
    output logic               udp_tx_enable_o,
    output logic               message_sending_o,
    output logic               data_accept_o
);

    fee_pkg::sys_status_t sys_status;
    fee_pkg::fee_mode_t   cfg_mode;
    rib_pkg::rib_data_t   test_word;
    fee_pkg::chan_bank_t  baseline;
    fee_pkg::chan_bank_t  noise;
    fee_pkg::chan_bank_t  samples;

    rib_regs u_rib_regs (
        .clk              (clk),
        .rst              (rst),
        .rib_req_i        (rib_req_i),
        .adc_data_i       (adc_data_i),
        .adc_data_ready_i (adc_data_ready_i),
        .capture_en_i     (fifo_wr_en_o),      // Capture while FIFO writes run
        .udp_cfg_o        (udp_cfg_o),
        .sys_status_o     (sys_status),
        .cfg_mode_o       (cfg_mode),
        .test_word_o      (test_word),
        .baseline_o       (baseline),
        .noise_o          (noise),
        .samples_o        (samples)
    );

    rib_readback u_rib_readback (
        .rib_addr_i   (rib_req_i.addr),
        .udp_cfg_i    (udp_cfg_o),
        .sys_status_i (sys_status),
        .fee_mode_i   (fee_mode_o),
        .udp_tx_req_i (udp_stat_i.tx_req),
        .test_word_i  (test_word),
        .baseline_i   (baseline),
        .noise_i      (noise),
        .samples_i    (samples),
        .rib_rdata_o  (rib_rdata_o)
    );

    fee_ctrl_fsm u_fee_ctrl_fsm (
        .clk               (clk),
        .rst               (rst),
        .cfg_mode_i        (cfg_mode),
        .sys_status_i      (sys_status),
        .cfg_fifo_wr_en_i  (udp_cfg_o.fifo_wr_en),
        .cfg_tx_enable_i   (udp_cfg_o.tx_enable),
        .udp_stat_i        (udp_stat_i),
        .fee_mode_o        (fee_mode_o),
        .fifo_wr_en_o      (fifo_wr_en_o),
        .udp_tx_enable_o   (udp_tx_enable_o),
        .message_sending_o (message_sending_o)
    );

    packet_trigger u_packet_trigger (
        .clk             (clk),
        .rst             (rst),
        .udp_tx_done_i   (udp_stat_i.tx_done),
        .udp_tx_enable_i (udp_tx_enable_o),
        .sys_status_i    (sys_status),
        .data_accept_o   (data_accept_o)
    );

endmodule

/* include/fee_tb_vectors.svh */
`ifndef FEE_TB_VECTORS_SVH
`define FEE_TB_VECTORS_SVH

// One bus operation, exp is checked on reads only
typedef struct packed {
    logic               wr;
    rib_pkg::rib_addr_t addr;
    rib_pkg::rib_data_t data;
    rib_pkg::rib_data_t exp;
} tb_vec_t;

localparam int TB_NUM_VECS = 47;

localparam tb_vec_t TB_VECS [TB_NUM_VECS] = '{
    '{1'b1, 32'h0000_0010, 32'h0001_00C8, 32'h0}, '{1'b0, 32'h0000_0010, 32'h0, 32'h0001_00C8},
    '{1'b1, 32'h0000_0014, 32'hC0A8_0A01, 32'h0}, '{1'b0, 32'h0000_0014, 32'h0, 32'hC0A8_0A01},
    '{1'b1, 32'h0000_0018, 32'hC0A8_0A02, 32'h0}, '{1'b0, 32'h0000_0018, 32'h0, 32'hC0A8_0A02},
    '{1'b1, 32'h0000_001C, 32'hFFFF_04D3, 32'h0}, '{1'b0, 32'h0000_001C, 32'h0, 32'h0000_04D3},
    '{1'b1, 32'h0000_0020, 32'h0000_1F90, 32'h0}, '{1'b0, 32'h0000_0020, 32'h0, 32'h0000_1F90},
    '{1'b1, 32'h0000_002C, 32'hA5A5_5A5A, 32'h0}, '{1'b0, 32'h0000_002C, 32'h0, 32'hA5A5_5A5A},
    // Upper baseline write bits must not stick
    '{1'b1, 32'h0000_2000, 32'hFFFF_B000, 32'h0}, '{1'b0, 32'h0000_2000, 32'h0, 32'h0000_B000},
    '{1'b1, 32'h0000_2008, 32'hFFFF_B001, 32'h0}, '{1'b0, 32'h0000_2008, 32'h0, 32'h0000_B001},
    '{1'b1, 32'h0000_2010, 32'hFFFF_B002, 32'h0}, '{1'b0, 32'h0000_2010, 32'h0, 32'h0000_B002},
    '{1'b1, 32'h0000_2018, 32'hFFFF_B003, 32'h0}, '{1'b0, 32'h0000_2018, 32'h0, 32'h0000_B003},
    '{1'b1, 32'h0000_2020, 32'hFFFF_B004, 32'h0}, '{1'b0, 32'h0000_2020, 32'h0, 32'h0000_B004},
    '{1'b1, 32'h0000_2028, 32'hFFFF_B005, 32'h0}, '{1'b0, 32'h0000_2028, 32'h0, 32'h0000_B005},
    '{1'b1, 32'h0000_2030, 32'hFFFF_B006, 32'h0}, '{1'b0, 32'h0000_2030, 32'h0, 32'h0000_B006},
    '{1'b1, 32'h0000_2038, 32'hFFFF_B007, 32'h0}, '{1'b0, 32'h0000_2038, 32'h0, 32'h0000_B007},
    // Noise
    '{1'b1, 32'h0000_3000, 32'h0000_C000, 32'h0}, '{1'b0, 32'h0000_3000, 32'h0, 32'h0000_C000},
    '{1'b1, 32'h0000_3008, 32'h0000_C101, 32'h0}, '{1'b0, 32'h0000_3008, 32'h0, 32'h0000_C101},
    '{1'b1, 32'h0000_3010, 32'h0000_C202, 32'h0}, '{1'b0, 32'h0000_3010, 32'h0, 32'h0000_C202},
    '{1'b1, 32'h0000_3018, 32'h0000_C303, 32'h0}, '{1'b0, 32'h0000_3018, 32'h0, 32'h0000_C303},
    '{1'b1, 32'h0000_3020, 32'h0000_C404, 32'h0}, '{1'b0, 32'h0000_3020, 32'h0, 32'h0000_C404},
    '{1'b1, 32'h0000_3028, 32'h0000_C505, 32'h0}, '{1'b0, 32'h0000_3028, 32'h0, 32'h0000_C505},
    '{1'b1, 32'h0000_3030, 32'h0000_C606, 32'h0}, '{1'b0, 32'h0000_3030, 32'h0, 32'h0000_C606},
    '{1'b1, 32'h0000_3038, 32'h0000_C707, 32'h0}, '{1'b0, 32'h0000_3038, 32'h0, 32'h0000_C707},
    // Channel 8 is out of range and 0x04 is not mapped
    '{1'b1, 32'h0000_2040, 32'h0000_1234, 32'h0}, '{1'b0, 32'h0000_2040, 32'h0, 32'hDEAD_BEEF},
    '{1'b0, 32'h0000_0004, 32'h0, 32'hDEAD_BEEF}
};

`endif

/* test/tb_fee_top.sv */
`timescale 1ns/1ps

module tb_fee_top;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int SIG_MSG        = 0;
    localparam int SIG_FIFO       = 1;
    localparam int SIG_TXEN       = 2;
    localparam int SIG_ACCEPT     = 3;

    `include "fee_tb_vectors.svh"

    logic               clk;
    logic               rst;
    rib_pkg::rib_req_t  rib_req;
    rib_pkg::rib_data_t rib_rdata;
    fee_pkg::adc_bus_t  adc_data;
    logic               adc_data_ready;
    rib_pkg::udp_stat_t udp_stat;
    rib_pkg::udp_cfg_t  udp_cfg;
    fee_pkg::fee_mode_t fee_mode;
    logic               fifo_wr_en;
    logic               udp_tx_enable;
    logic               message_sending;
    logic               data_accept;

    fee_top u_fee_top (
        .clk               (clk),
        .rst               (rst),
        .rib_req_i         (rib_req),
        .rib_rdata_o       (rib_rdata),
        .adc_data_i        (adc_data),
        .adc_data_ready_i  (adc_data_ready),
        .udp_stat_i        (udp_stat),
        .udp_cfg_o         (udp_cfg),
        .fee_mode_o        (fee_mode),
        .fifo_wr_en_o      (fifo_wr_en),
        .udp_tx_enable_o   (udp_tx_enable),
        .message_sending_o (message_sending),
        .data_accept_o     (data_accept)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, msg, actual, expected);
            abort_run();
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SIG_MSG:  return message_sending;
            SIG_FIFO: return fifo_wr_en;
            SIG_TXEN: return udp_tx_enable;
            default:  return data_accept;
        endcase
    endfunction

    // Polled at the falling edge where outputs are settled
    task automatic wait_level(input int sel, input logic level, input string what);
        int n;
        for (n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(negedge clk);
            if (probe(sel) === level) break;
        end
        if (n == TIMEOUT_CYCLES) begin
            $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
            abort_run();
        end
    endtask

    task automatic bus_write(input rib_pkg::rib_addr_t addr, input rib_pkg::rib_data_t data);
        @(posedge clk);
        #1;
        rib_req = '{addr: addr, wdata: data, we: 1'b1};
    endtask

    task automatic read_expect(input rib_pkg::rib_addr_t addr, input rib_pkg::rib_data_t exp,
                               input string msg);
        @(posedge clk);
        #1;
        rib_req = '{addr: addr, wdata: '0, we: 1'b0};
        @(negedge clk);
        check(rib_rdata, exp, msg);
    endtask

    task automatic pulse_tx_done();
        @(posedge clk);
        #1;
        udp_stat.tx_done = 1'b1;
        @(posedge clk);
        #1;
        udp_stat.tx_done = 1'b0;
    endtask

    // Mode change opens a message, tx_done closes it
    task automatic close_message(input fee_pkg::fee_mode_t mode);
        wait_level(SIG_MSG, 1'b1, "message state entry");
        check(fee_mode, mode, "operating mode after change");
        pulse_tx_done();
        wait_level(SIG_MSG, 1'b0, "message state exit");
    endtask

    initial begin
        fee_pkg::adc_sample_t smp [fee_pkg::NUM_CHANNELS];
        int                   hits;
        int                   hit_at;

        clk            = 1'b0;
        rst            = 1'b0;
        rib_req        = '0;
        adc_data       = '0;
        adc_data_ready = 1'b0;
        udp_stat       = '{tx_done: 1'b0, busy: 1'b0, end_tran: 1'b0, tx_req: 1'b0,
                           prog_empty: 1'b1};
        void'($urandom(32'h639ba8ee));

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check({fifo_wr_en, udp_tx_enable, message_sending, data_accept}, 32'h0,
              "control outputs after reset");
        check(fee_mode, 32'h0, "operating mode after reset");
        check(udp_cfg.tx_data_num, 32'd100, "config output data count after reset");
        check({udp_cfg.fifo_wr_en, udp_cfg.tx_enable}, 32'b01,
              "config output enables after reset");
        check(udp_cfg.board_ip, 32'hC0A8_B96F, "config output board IP after reset");
        check(udp_cfg.des_ip, 32'hC0A8_B9F3, "config output dest IP after reset");
        check({udp_cfg.board_port, udp_cfg.des_port}, {16'd1234, 16'd1234},
              "config output ports after reset");
        read_expect(rib_pkg::REG_UDP_CONFIG, 32'h0001_0064, "reset UDP config");
        read_expect(rib_pkg::REG_BOARD_IP, 32'hC0A8_B96F, "reset board IP");   // 192.168.185.111
        read_expect(rib_pkg::REG_DES_IP, 32'hC0A8_B9F3, "reset dest IP");      // 192.168.185.243
        read_expect(rib_pkg::REG_BOARD_PORT, 32'd1234, "reset board port");
        read_expect(rib_pkg::REG_DES_PORT, 32'd1234, "reset dest port");

        for (int i = 0; i < TB_NUM_VECS; i++) begin
            if (TB_VECS[i].wr) begin
                bus_write(TB_VECS[i].addr, TB_VECS[i].data);
            end else begin
                read_expect(TB_VECS[i].addr, TB_VECS[i].exp, $sformatf("table row %0d", i));
            end
        end

        // Written configuration also leaves on the config output
        check(udp_cfg.tx_data_num, 32'd200, "config output data count");
        check(udp_cfg.board_ip, 32'hC0A8_0A01, "config output board IP");
        check(udp_cfg.des_ip, 32'hC0A8_0A02, "config output dest IP");
        check({udp_cfg.board_port, udp_cfg.des_port}, 32'h04D3_1F90, "config output ports");

        // Status word per operating mode
        bus_write(rib_pkg::REG_SYS_STATUS, fee_pkg::STAT_MEASURE_START);
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd0, "status in idle mode");
        bus_write(rib_pkg::REG_SYS_MODE, fee_pkg::MODE_ACQUISITION);
        close_message(fee_pkg::MODE_ACQUISITION);
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd4, "status in acquisition");
        bus_write(rib_pkg::REG_SYS_STATUS, fee_pkg::STAT_UDP_REQ_WAIT);
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd0, "request wait, tx_req low");
        @(posedge clk);
        #1;
        udp_stat.tx_req = 1'b1;
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd8, "request wait, tx_req high");
        @(posedge clk);
        #1;
        udp_stat.tx_req = 1'b0;
        bus_write(rib_pkg::REG_SYS_MODE, fee_pkg::MODE_CALIBRATION);
        close_message(fee_pkg::MODE_CALIBRATION);
        read_expect(rib_pkg::REG_SYS_MODE, 32'd1, "operating mode readback");
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd2, "status in calibration");
        bus_write(rib_pkg::REG_SYS_STATUS, fee_pkg::STAT_MEASURE_FINISH);
        read_expect(rib_pkg::REG_SYS_STATUS, 32'd3, "finished calibration status");

        // Finished measurement keeps the accept strobe up
        wait_level(SIG_ACCEPT, 1'b1, "data_accept on finished measurement");
        repeat (5) begin
            @(negedge clk);
            check(data_accept, 32'd1, "data_accept held while measurement finished");
        end

        bus_write(rib_pkg::REG_SYS_STATUS, fee_pkg::STAT_INIT_FINISH);
        bus_write(rib_pkg::REG_SYS_MODE, fee_pkg::MODE_ACQUISITION);
        bus_write(rib_pkg::REG_UDP_CONFIG, 32'h0003_0064);    // fifo_wr_en and tx_enable
        close_message(fee_pkg::MODE_ACQUISITION);
        wait_level(SIG_FIFO, 1'b1, "capture start");
        check(udp_tx_enable, 32'd0, "tx enable during capture");
        check({udp_cfg.fifo_wr_en, udp_cfg.tx_enable}, 32'b11, "config output enables");

        repeat (2) begin
            @(posedge clk);
            #1;
            for (int ch = 0; ch < fee_pkg::NUM_CHANNELS; ch++) begin
                smp[ch]      = fee_pkg::adc_sample_t'($urandom);
                adc_data[ch] = smp[ch];
            end
            adc_data_ready = 1'b1;
            @(posedge clk);
            #1;
            adc_data_ready = 1'b0;
            adc_data       = '0;    // Readback must come from the latch
            for (int ch = 0; ch < fee_pkg::NUM_CHANNELS; ch++) begin
                read_expect(32'h1000 + ch * 8, {20'h0, smp[ch]}, "ADC sample readback");
            end
        end

        @(posedge clk);
        #1;
        udp_stat.busy       = 1'b1;
        udp_stat.prog_empty = 1'b0;
        wait_level(SIG_TXEN, 1'b1, "transmit start");
        check({fifo_wr_en, message_sending}, 32'b10, "outputs during transmit");
        bus_write(rib_pkg::REG_UDP_CONFIG, 32'h0001_0064);    // No capture after this transfer
        @(posedge clk);
        #1;
        udp_stat.busy       = 1'b0;
        udp_stat.prog_empty = 1'b1;
        wait_level(SIG_TXEN, 1'b0, "transmit end");
        check({fifo_wr_en, message_sending}, 32'h0, "outputs after transmit");
        read_expect(rib_pkg::REG_UDP_CONFIG, 32'h0001_0064, "config after transmit");
        check({fifo_wr_en, udp_tx_enable, message_sending}, 32'h0, "outputs stay idle");

        // The pulse lands at k=3 when the first edge sampling tx_done is k=1
        hits   = 0;
        hit_at = 0;
        @(posedge clk);
        #1;
        udp_stat.tx_done = 1'b1;
        for (int k = 1; k <= 8; k++) begin
            @(posedge clk);
            #1;
            udp_stat.tx_done = 1'b0;
            @(negedge clk);
            if (data_accept) begin
                hits++;
                hit_at = k;
            end
        end
        check(hits, 32'd1, "data_accept pulse count");
        check(hit_at, 32'd3, "data_accept delay after tx_done edge");

        $display("Test OK");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
logic/rib_pkg.sv
logic/fee_pkg.sv
logic/rib_regs.sv
logic/rib_readback.sv
logic/fee_ctrl_fsm.sv
logic/packet_trigger.sv
logic/fee_top.sv
test/tb_fee_top.sv

/* Bender.yml */
package:
  name: fee_slow_control

sources:
  - logic/rib_pkg.sv
  - logic/fee_pkg.sv
  - logic/rib_regs.sv
  - logic/rib_readback.sv
  - logic/fee_ctrl_fsm.sv
  - logic/packet_trigger.sv
  - logic/fee_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_fee_top.sv
